/* alut.f */
+incdir+hw
hw/alut_pkg.sv
hw/alut_reg_bank.sv
hw/alut_time_base.sv
hw/alut_table.sv
hw/alut_addr_checker.sv
hw/alut_age_checker.sv
hw/alut.sv
tests/alut_tb.sv

/* hw/alut.sv */
// address lookup unit top level
// apb register bank, time base, address table and the two checkers
`timescale 1ns/10ps
`include "alut_defines.svh"

module alut
   import alut_pkg::*;
(
   input  logic        pclk9,
   input  logic        n_p_reset9,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);

   // register bank outputs
   logic [47:0]            mac_addr;
   logic [47:0]            d_addr;
   logic [47:0]            s_addr;
   logic [1:0]             s_port;
   logic [31:0]            best_bfr_age;
   logic [7:0]             div_clk;
   alut_cmd_e              command;
   logic                   clear_reused;
   logic [31:0]            curr_time;

   // address checker side
   logic [`ALUT_IDX_W-1:0] add_rd_idx;
   alut_entry_t            add_rd_entry;
   logic                   add_wr;
   logic [`ALUT_IDX_W-1:0] add_wr_idx;
   alut_entry_t            add_wr_entry;
   logic                   add_check_active;
   logic [4:0]             d_port;
   logic                   reused;
   logic [47:0]            lst_inv_addr_nrm;
   logic [1:0]             lst_inv_port_nrm;

   // age checker side
   logic [`ALUT_IDX_W-1:0] age_rd_idx;
   alut_entry_t            age_rd_entry;
   logic                   age_wr;
   logic [`ALUT_IDX_W-1:0] age_wr_idx;
   alut_entry_t            age_wr_entry;
   logic                   age_check_active;
   logic                   inval_in_prog;
   logic [47:0]            lst_inv_addr_cmd;
   logic [1:0]             lst_inv_port_cmd;

   alut_reg_bank i_reg_bank
   (
      .pclk9            (pclk9),
      .n_p_reset9       (n_p_reset9),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .curr_time        (curr_time),
      .add_check_active (add_check_active),
      .age_check_active (age_check_active),
      .inval_in_prog    (inval_in_prog),
      .reused           (reused),
      .d_port           (d_port),
      .lst_inv_addr_nrm (lst_inv_addr_nrm),
      .lst_inv_port_nrm (lst_inv_port_nrm),
      .lst_inv_addr_cmd (lst_inv_addr_cmd),
      .lst_inv_port_cmd (lst_inv_port_cmd),
      .mac_addr         (mac_addr),
      .d_addr           (d_addr),
      .s_addr           (s_addr),
      .s_port           (s_port),
      .best_bfr_age     (best_bfr_age),
      .div_clk          (div_clk),
      .command          (command),
      .prdata           (prdata),
      .clear_reused     (clear_reused)
   );

   alut_time_base i_time_base
   (
      .pclk9      (pclk9),
      .n_p_reset9 (n_p_reset9),
      .div_clk    (div_clk),
      .curr_time  (curr_time)
   );

   alut_table i_table
   (
      .pclk9        (pclk9),
      .n_p_reset9   (n_p_reset9),
      .add_rd_idx   (add_rd_idx),
      .add_wr       (add_wr),
      .add_wr_idx   (add_wr_idx),
      .add_wr_entry (add_wr_entry),
      .age_rd_idx   (age_rd_idx),
      .age_wr       (age_wr),
      .age_wr_idx   (age_wr_idx),
      .age_wr_entry (age_wr_entry),
      .add_rd_entry (add_rd_entry),
      .age_rd_entry (age_rd_entry)
   );

   alut_addr_checker i_addr_checker
   (
      .pclk9            (pclk9),
      .n_p_reset9       (n_p_reset9),
      .command          (command),
      .mac_addr         (mac_addr),
      .d_addr           (d_addr),
      .s_addr           (s_addr),
      .s_port           (s_port),
      .curr_time        (curr_time),
      .clear_reused     (clear_reused),
      .rd_entry         (add_rd_entry),
      .rd_idx           (add_rd_idx),
      .wr               (add_wr),
      .wr_idx           (add_wr_idx),
      .wr_entry         (add_wr_entry),
      .add_check_active (add_check_active),
      .d_port           (d_port),
      .reused           (reused),
      .lst_inv_addr_nrm (lst_inv_addr_nrm),
      .lst_inv_port_nrm (lst_inv_port_nrm)
   );

   alut_age_checker i_age_checker
   (
      .pclk9            (pclk9),
      .n_p_reset9       (n_p_reset9),
      .command          (command),
      .curr_time        (curr_time),
      .best_bfr_age     (best_bfr_age),
      .rd_entry         (age_rd_entry),
      .rd_idx           (age_rd_idx),
      .wr               (age_wr),
      .wr_idx           (age_wr_idx),
      .wr_entry         (age_wr_entry),
      .age_check_active (age_check_active),
      .inval_in_prog    (inval_in_prog),
      .lst_inv_addr_cmd (lst_inv_addr_cmd),
      .lst_inv_port_cmd (lst_inv_port_cmd)
   );

endmodule

/* hw/alut_addr_checker.sv */
// address checker fsm
// scans the table for the destination, then learns the source
// in one write, reporting a reused entry on a full table
`timescale 1ns/10ps
`include "alut_defines.svh"

module alut_addr_checker
   import alut_pkg::*;
(
   input  logic                   pclk9,
   input  logic                   n_p_reset9,
   input  alut_cmd_e              command,
   input  logic [47:0]            mac_addr,
   input  logic [47:0]            d_addr,
   input  logic [47:0]            s_addr,
   input  logic [1:0]             s_port,
   input  logic [31:0]            curr_time,
   input  logic                   clear_reused,
   input  alut_entry_t            rd_entry,
   output logic [`ALUT_IDX_W-1:0] rd_idx,
   output logic                   wr,
   output logic [`ALUT_IDX_W-1:0] wr_idx,
   output alut_entry_t            wr_entry,
   output logic                   add_check_active,
   output logic [4:0]             d_port,
   output logic                   reused,
   output logic [47:0]            lst_inv_addr_nrm,
   output logic [1:0]             lst_inv_port_nrm
);

   addr_state_e            state;
   logic [`ALUT_IDX_W-1:0] scan_idx;
   logic                   d_hit;        // destination found
   logic [1:0]             d_hit_port;
   logic                   s_hit;        // source already learned
   logic [`ALUT_IDX_W-1:0] s_hit_idx;
   logic                   free_found;
   logic [`ALUT_IDX_W-1:0] free_idx;     // lowest invalid index
   logic [`ALUT_IDX_W-1:0] old_idx;      // oldest stamp so far
   logic [31:0]            old_stamp;
   logic                   learn;
   logic                   reuse;
   logic [4:0]             d_port_nxt;

   assign add_check_active = (state != ADD_IDLE);
   assign learn  = (state == ADD_LEARN);
   assign reuse  = learn & ~s_hit & ~free_found;   // table full, evict oldest
   assign rd_idx = learn ? old_idx : scan_idx;      // learn reads back the victim

   assign wr       = learn;
   assign wr_idx   = s_hit ? s_hit_idx : (free_found ? free_idx : old_idx);
   assign wr_entry = '{valid: 1'b1, mac: s_addr, port: s_port, stamp: curr_time};

   always_comb
   begin
      if (d_addr == mac_addr)
         d_port_nxt = 5'b1_0000;                      // for the switch itself
      else if (d_hit)
         d_port_nxt = {1'b0, 4'b0001 << d_hit_port};
      else
         d_port_nxt = {1'b0, ~(4'b0001 << s_port)};   // flood, all but source
   end

   // -------------------------------------------------------------------------
   // control, 8 scan cycles then 1 learn cycle
   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         state    <= ADD_IDLE;
         scan_idx <= '0;
         d_port   <= '0;
         reused   <= 1'b0;
      end
      else
      begin
         case (state)
            ADD_IDLE :
               if (command == CMD_CHECK)
               begin
                  state    <= ADD_SCAN;
                  scan_idx <= '0;
               end
            ADD_SCAN :
            begin
               scan_idx <= scan_idx + 1'b1;
               if (scan_idx == `ALUT_IDX_W'(`ALUT_DEPTH - 1))
                  state <= ADD_LEARN;
            end
            default :   // learn
            begin
               state  <= ADD_IDLE;
               d_port <= d_port_nxt;
            end
         endcase
         if (reuse)
            reused <= 1'b1;        // sticky until status read
         else if (clear_reused)
            reused <= 1'b0;
      end
   end

   // -------------------------------------------------------------------------
   // scan results, cleared while idle
   always_ff @(posedge pclk9)
   begin
      if (state == ADD_IDLE)
      begin
         d_hit      <= 1'b0;
         s_hit      <= 1'b0;
         free_found <= 1'b0;
      end
      else if (state == ADD_SCAN)
      begin
         if (rd_entry.valid && (rd_entry.mac == d_addr) && !d_hit)
         begin
            d_hit      <= 1'b1;
            d_hit_port <= rd_entry.port;
         end
         if (rd_entry.valid && (rd_entry.mac == s_addr))
         begin
            s_hit     <= 1'b1;
            s_hit_idx <= scan_idx;
         end
         if (!rd_entry.valid && !free_found)
         begin
            free_found <= 1'b1;
            free_idx   <= scan_idx;
         end
         // strict compare keeps the lowest index on a tie
         if ((scan_idx == '0) ||
             ((curr_time - rd_entry.stamp) > (curr_time - old_stamp)))
         begin
            old_idx   <= scan_idx;
            old_stamp <= rd_entry.stamp;
         end
      end
   end

   // evicted entry, seen on the read port during learn
   always_ff @(posedge pclk9)
   begin
      if (reuse)
      begin
         lst_inv_addr_nrm <= rd_entry.mac;
         lst_inv_port_nrm <= rd_entry.port;
      end
   end

endmodule

/* hw/alut_age_checker.sv */
// age checker fsm
// sweeps every table entry once, invalidating those past best before age
`timescale 1ns/10ps
`include "alut_defines.svh"

module alut_age_checker
   import alut_pkg::*;
(
   input  logic                   pclk9,
   input  logic                   n_p_reset9,
   input  alut_cmd_e              command,
   input  logic [31:0]            curr_time,
   input  logic [31:0]            best_bfr_age,
   input  alut_entry_t            rd_entry,
   output logic [`ALUT_IDX_W-1:0] rd_idx,
   output logic                   wr,
   output logic [`ALUT_IDX_W-1:0] wr_idx,
   output alut_entry_t            wr_entry,
   output logic                   age_check_active,
   output logic                   inval_in_prog,
   output logic [47:0]            lst_inv_addr_cmd,
   output logic [1:0]             lst_inv_port_cmd
);

   age_state_e             state;
   logic [`ALUT_IDX_W-1:0] sweep_idx;
   logic                   aged;

   assign age_check_active = (state == AGE_SWEEP);
   assign rd_idx = sweep_idx;

   // age mod 2^32, so a wrapped curr_time still gives the right age
   assign aged = age_check_active & rd_entry.valid &
                 ((curr_time - rd_entry.stamp) > best_bfr_age);

   assign wr     = aged;
   assign wr_idx = sweep_idx;
   always_comb
   begin
      wr_entry       = rd_entry;
      wr_entry.valid = 1'b0;   // only the valid bit changes
   end

   assign inval_in_prog    = aged;
   assign lst_inv_addr_cmd = rd_entry.mac;
   assign lst_inv_port_cmd = rd_entry.port;

   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         state     <= AGE_IDLE;
         sweep_idx <= '0;
      end
      else if (state == AGE_IDLE)
      begin
         if (command == CMD_AGE)
         begin
            state     <= AGE_SWEEP;
            sweep_idx <= '0;
         end
      end
      else
      begin
         sweep_idx <= sweep_idx + 1'b1;   // one entry per cycle
         if (sweep_idx == `ALUT_IDX_W'(`ALUT_DEPTH - 1))
            state <= AGE_IDLE;
      end
   end

   // a sweep covers the whole table and then stops
   a_sweep_len : assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      $rose(age_check_active) |-> age_check_active [*`ALUT_DEPTH] ##1 !age_check_active);

endmodule

/* hw/alut_defines.svh */
// address lookup unit constants
// apb register offsets, table depth and table index width
`ifndef ALUT_DEFINES_SVH
`define ALUT_DEFINES_SVH

// apb register offsets, byte addressed, 7 bit paddr
`define AL_FRM_D_ADDR_L    7'h00
`define AL_FRM_D_ADDR_U    7'h04
`define AL_FRM_S_ADDR_L    7'h08
`define AL_FRM_S_ADDR_U    7'h0C
`define AL_S_PORT          7'h10
`define AL_D_PORT          7'h14
`define AL_MAC_ADDR_L      7'h18
`define AL_MAC_ADDR_U      7'h1C
`define AL_CUR_TIME        7'h20
`define AL_BB_AGE          7'h24
`define AL_DIV_CLK         7'h28
`define AL_STATUS          7'h2C
`define AL_COMMAND         7'h30
`define AL_LST_INV_ADDR_L  7'h34
`define AL_LST_INV_ADDR_U  7'h38
`define AL_LST_INV_PORT    7'h3C

// learned address table, index width is log2 of depth
`define ALUT_DEPTH         8
`define ALUT_IDX_W         3

`endif

/* hw/alut_pkg.sv */
// shared types of the address lookup unit
// command codes, table entry layout, checker fsm states
package alut_pkg;

   // software command, 2'b11 reserved and ignored
   typedef enum logic [1:0]
   {
      CMD_NONE  = 2'b00,
      CMD_AGE   = 2'b01,
      CMD_CHECK = 2'b10,
      CMD_RSVD  = 2'b11
   } alut_cmd_e;

   // one learned address, 83 bits
   typedef struct packed
   {
      logic        valid;
      logic [47:0] mac;
      logic [1:0]  port;
      logic [31:0] stamp;   // curr_time when learned
   } alut_entry_t;

   typedef enum logic [1:0] {ADD_IDLE, ADD_SCAN, ADD_LEARN} addr_state_e;
   typedef enum logic {AGE_IDLE, AGE_SWEEP} age_state_e;

endpackage

/* hw/alut_reg_bank.sv */
// apb register file of the address lookup unit
// registered read mux, writable registers, self clearing command
// last invalidated entry capture
`timescale 1ns/10ps
`include "alut_defines.svh"

module alut_reg_bank
   import alut_pkg::*;
(
   input  logic        pclk9,
   input  logic        n_p_reset9,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   input  logic [31:0] curr_time,
   input  logic        add_check_active,
   input  logic        age_check_active,
   input  logic        inval_in_prog,      // status[1]
   input  logic        reused,             // status[2]
   input  logic [4:0]  d_port,
   input  logic [47:0] lst_inv_addr_nrm,   // victim of a table full learn
   input  logic [1:0]  lst_inv_port_nrm,
   input  logic [47:0] lst_inv_addr_cmd,   // entry aged out by a sweep
   input  logic [1:0]  lst_inv_port_cmd,
   output logic [47:0] mac_addr,
   output logic [47:0] d_addr,
   output logic [47:0] s_addr,
   output logic [1:0]  s_port,
   output logic [31:0] best_bfr_age,
   output logic [7:0]  div_clk,
   output alut_cmd_e   command,
   output logic [31:0] prdata,
   output logic        clear_reused
);

   logic        read_enable;
   logic        write_enable;
   logic        active;
   logic [31:0] frm_d_addr_l;
   logic [15:0] frm_d_addr_u;
   logic [31:0] frm_s_addr_l;
   logic [15:0] frm_s_addr_u;
   logic [31:0] mac_addr_l;
   logic [15:0] mac_addr_u;
   logic [31:0] lst_inv_addr_l;
   logic [15:0] lst_inv_addr_u;
   logic [1:0]  lst_inv_port;

   assign read_enable  = psel & ~penable & ~pwrite;   // setup phase
   assign write_enable = psel & penable & pwrite;     // access phase
   assign active       = add_check_active | age_check_active;
   // status read acknowledges reuse, but only once things are quiet
   assign clear_reused = read_enable & (paddr == `AL_STATUS) & ~active;

   assign mac_addr = {mac_addr_u, mac_addr_l};
   assign d_addr   = {frm_d_addr_u, frm_d_addr_l};
   assign s_addr   = {frm_s_addr_u, frm_s_addr_l};

   // -------------------------------------------------------------------------
   // read mux, data valid during the access phase only
   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
         prdata <= '0;
      else if (read_enable)
      begin
         case (paddr)
            `AL_FRM_D_ADDR_L   : prdata <= frm_d_addr_l;
            `AL_FRM_D_ADDR_U   : prdata <= {16'd0, frm_d_addr_u};
            `AL_FRM_S_ADDR_L   : prdata <= frm_s_addr_l;
            `AL_FRM_S_ADDR_U   : prdata <= {16'd0, frm_s_addr_u};
            `AL_S_PORT         : prdata <= {30'd0, s_port};
            `AL_D_PORT         : prdata <= {27'd0, d_port};
            `AL_MAC_ADDR_L     : prdata <= mac_addr_l;
            `AL_MAC_ADDR_U     : prdata <= {16'd0, mac_addr_u};
            `AL_CUR_TIME       : prdata <= curr_time;
            `AL_BB_AGE         : prdata <= best_bfr_age;
            `AL_DIV_CLK        : prdata <= {24'd0, div_clk};
            `AL_STATUS         : prdata <= {29'd0, reused, inval_in_prog, active};
            `AL_LST_INV_ADDR_L : prdata <= lst_inv_addr_l;
            `AL_LST_INV_ADDR_U : prdata <= {16'd0, lst_inv_addr_u};
            `AL_LST_INV_PORT   : prdata <= {30'd0, lst_inv_port};
            default            : prdata <= '0;   // command and holes
         endcase
      end
      else
         prdata <= '0;
   end

   // -------------------------------------------------------------------------
   // software writable registers
   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         frm_d_addr_l <= '0;
         frm_d_addr_u <= '0;
         frm_s_addr_l <= '0;
         frm_s_addr_u <= '0;
         s_port       <= '0;
         mac_addr_l   <= '0;
         mac_addr_u   <= '0;
         best_bfr_age <= '1;   // nothing ages out by default
         div_clk      <= '0;
      end
      else if (write_enable)
      begin
         case (paddr)
            `AL_FRM_D_ADDR_L : frm_d_addr_l <= pwdata;
            `AL_FRM_D_ADDR_U : frm_d_addr_u <= pwdata[15:0];
            `AL_FRM_S_ADDR_L : frm_s_addr_l <= pwdata;
            `AL_FRM_S_ADDR_U : frm_s_addr_u <= pwdata[15:0];
            `AL_S_PORT       : s_port       <= pwdata[1:0];
            `AL_MAC_ADDR_L   : mac_addr_l   <= pwdata;
            `AL_MAC_ADDR_U   : mac_addr_u   <= pwdata[15:0];
            `AL_BB_AGE       : best_bfr_age <= pwdata;
            `AL_DIV_CLK      : div_clk      <= pwdata[7:0];
            default          : ;
         endcase
      end
   end

   // command is a one cycle pulse, dropped while a checker runs
   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
         command <= CMD_NONE;
      else if (command != CMD_NONE)
         command <= CMD_NONE;   // self clear
      else if (write_enable && (paddr == `AL_COMMAND) && !active)
         command <= alut_cmd_e'(pwdata[1:0]);
   end

   // -------------------------------------------------------------------------
   // last invalidated entry, a reuse by the address checker has priority
   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         lst_inv_addr_l <= '0;
         lst_inv_addr_u <= '0;
         lst_inv_port   <= '0;
      end
      else if (reused)
      begin
         lst_inv_addr_l <= lst_inv_addr_nrm[31:0];
         lst_inv_addr_u <= lst_inv_addr_nrm[47:32];
         lst_inv_port   <= lst_inv_port_nrm;
      end
      else if (inval_in_prog)
      begin
         lst_inv_addr_l <= lst_inv_addr_cmd[31:0];
         lst_inv_addr_u <= lst_inv_addr_cmd[47:32];
         lst_inv_port   <= lst_inv_port_cmd;
      end
   end

   // every setup phase runs into its own access phase
   a_apb_access : assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      (psel && !penable) |=> (psel && penable && $stable(paddr) && $stable(pwrite)));

   // a check or sweep command always starts its checker
   a_cmd_start : assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      (command inside {CMD_CHECK, CMD_AGE}) |=> active);

endmodule

/* hw/alut_table.sv */
// learned address table
// two combinational read ports, two write ports, address checker wins
`timescale 1ns/10ps
`include "alut_defines.svh"

module alut_table
   import alut_pkg::*;
(
   input  logic                   pclk9,
   input  logic                   n_p_reset9,
   input  logic [`ALUT_IDX_W-1:0] add_rd_idx,
   input  logic                   add_wr,
   input  logic [`ALUT_IDX_W-1:0] add_wr_idx,
   input  alut_entry_t            add_wr_entry,
   input  logic [`ALUT_IDX_W-1:0] age_rd_idx,
   input  logic                   age_wr,
   input  logic [`ALUT_IDX_W-1:0] age_wr_idx,
   input  alut_entry_t            age_wr_entry,
   output alut_entry_t            add_rd_entry,
   output alut_entry_t            age_rd_entry
);

   alut_entry_t            mem [`ALUT_DEPTH];
   logic [`ALUT_DEPTH-1:0] valid_q;     // separate so reset can clear it
   logic                   age_wr_ok;

   assign age_wr_ok = age_wr & ~(add_wr & (add_wr_idx == age_wr_idx));

   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
         valid_q <= '0;
      else
      begin
         if (age_wr_ok)
            valid_q[age_wr_idx] <= age_wr_entry.valid;
         if (add_wr)
            valid_q[add_wr_idx] <= add_wr_entry.valid;
      end
   end

   // payload, address, port and stamp
   always_ff @(posedge pclk9)
   begin
      if (age_wr_ok)
         mem[age_wr_idx] <= age_wr_entry;
      if (add_wr)
         mem[add_wr_idx] <= add_wr_entry;
   end

   always_comb
   begin
      add_rd_entry       = mem[add_rd_idx];
      add_rd_entry.valid = valid_q[add_rd_idx];
      age_rd_entry       = mem[age_rd_idx];
      age_rd_entry.valid = valid_q[age_rd_idx];
   end

   // the two checkers are never busy together
   a_no_dual_wr : assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      !(add_wr && age_wr && (add_wr_idx == age_wr_idx)));

endmodule

/* hw/alut_time_base.sv */
// time base of the address lookup unit
// programmable prescaler and free running current time counter
`timescale 1ns/10ps

module alut_time_base
(
   input  logic        pclk9,
   input  logic        n_p_reset9,
   input  logic [7:0]  div_clk,     // tick every div_clk+1 cycles
   output logic [31:0] curr_time
);

   logic [7:0] presc_cnt;
   logic       tick;

   // >= so a divider lowered mid count does not run the long way round
   assign tick = (presc_cnt >= div_clk);

   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         presc_cnt <= '0;
         curr_time <= '0;
      end
      else if (tick)
      begin
         presc_cnt <= '0;
         curr_time <= curr_time + 1'b1;   // wraps, ages are taken mod 2^32
      end
      else
         presc_cnt <= presc_cnt + 1'b1;
   end

endmodule

/* tests/alut_tb.sv */
// testbench of the address lookup unit
// apb write and read tasks, lfsr, row table of stimulus and expected values
// clock, reset, cycle limit
`timescale 1ns/10ps
`include "alut_defines.svh"

module alut_tb;

   // row operations
   localparam int OP_WR    = 0;   // apb write
   localparam int OP_RD    = 1;   // apb read and compare
   localparam int OP_IDLE  = 2;   // poll status bit 0 until clear
   localparam int OP_CYC   = 3;   // wait data cycles
   localparam int OP_TMARK = 4;   // read and keep a time sample
   localparam int OP_TDIFF = 5;   // read, diff against sample in data..expect

   localparam logic [47:0] MAC_M  = 48'h02C0_DE00_0001;   // switch own address
   localparam logic [47:0] ADDR_A = 48'h00A0_0000_000A;
   localparam logic [47:0] ADDR_B = 48'h00B0_0000_000B;
   localparam logic [47:0] ADDR_C = 48'h00C0_0000_000C;   // never learned

   logic        pclk9;
   logic        n_p_reset9;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   // stimulus table, one entry per row in each queue
   int          op_q[$];
   logic [6:0]  addr_q[$];
   logic [31:0] data_q[$];
   logic [31:0] exp_q[$];
   string       name_q[$];

   logic [31:0] lfsr_state = 32'h9e0d7b10;
   logic [31:0] time_mark;
   int          check_cnt = 0;
   int          fail_cnt  = 0;
   int          cycle_cnt = 0;
   int          cycle_limit = 1000000;   // replaced once the table is built
   int          row;

   alut UUT
   (
      .pclk9      (pclk9),
      .n_p_reset9 (n_p_reset9),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata)
   );

   initial pclk9 = 1'b0;
   always #2 pclk9 = ~pclk9;   // 4 ns period

   // run limit
   always @(posedge pclk9)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
      begin
         $display("timeout, run still busy after %0d cycles", cycle_cnt);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // random data, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_state = lfsr_next(lfsr_state);   // one step per bit
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic [47:0] src_addr(input int i);
      return 48'h0051_0000_0000 + 48'(i);
   endfunction

   // ------------------------------------------------------------------------
   // table building
   task automatic add_row(input int op, input logic [6:0] a, input logic [31:0] d,
                          input logic [31:0] e, input string n);
      op_q.push_back(op);
      addr_q.push_back(a);
      data_q.push_back(d);
      exp_q.push_back(e);
      name_q.push_back(n);
   endtask

   task automatic write_row(input logic [6:0] a, input logic [31:0] d);
      add_row(OP_WR, a, d, '0, "");
   endtask

   task automatic check_row(input logic [6:0] a, input logic [31:0] e, input string n);
      add_row(OP_RD, a, '0, e, n);
   endtask

   // frame registers plus check command, then idle poll or a fixed wait
   task automatic frame_rows(input logic [47:0] d, input logic [47:0] s,
                             input logic [1:0] p, input bit poll);
      write_row(`AL_FRM_D_ADDR_L, d[31:0]);
      write_row(`AL_FRM_D_ADDR_U, {16'd0, d[47:32]});
      write_row(`AL_FRM_S_ADDR_L, s[31:0]);
      write_row(`AL_FRM_S_ADDR_U, {16'd0, s[47:32]});
      write_row(`AL_S_PORT, {30'd0, p});
      write_row(`AL_COMMAND, 32'd2);   // check frame
      if (poll)
         add_row(OP_IDLE, '0, '0, '0, "");
      else
         add_row(OP_CYC, '0, 32'd16, '0, "");   // 9 active cycles, status untouched
   endtask

   task automatic build_table();
      logic [31:0] v;
      // register reset and round trip
      check_row(`AL_BB_AGE, 32'hFFFF_FFFF, "bb_age reset");
      v = rand_bits(32);
      write_row(`AL_MAC_ADDR_L, v);
      check_row(`AL_MAC_ADDR_L, v, "rt mac_addr_l");
      v = rand_bits(32);
      write_row(`AL_MAC_ADDR_U, v);
      check_row(`AL_MAC_ADDR_U, v & 32'h0000_FFFF, "rt mac_addr_u");
      v = rand_bits(32);
      write_row(`AL_BB_AGE, v);
      check_row(`AL_BB_AGE, v, "rt bb_age");
      v = rand_bits(32);
      write_row(`AL_DIV_CLK, v);
      check_row(`AL_DIV_CLK, v & 32'h0000_00FF, "rt div_clk");
      check_row(`AL_COMMAND, '0, "command reads zero");
      check_row(7'h40, '0, "unmapped 0x40");
      check_row(7'h7C, '0, "unmapped 0x7c");
      write_row(`AL_BB_AGE, 32'hFFFF_FFFF);
      write_row(`AL_DIV_CLK, '0);   // time runs every cycle from here

      // lookup miss, hit and own address
      write_row(`AL_MAC_ADDR_L, MAC_M[31:0]);
      write_row(`AL_MAC_ADDR_U, {16'd0, MAC_M[47:32]});
      frame_rows(ADDR_C, ADDR_A, 2'd2, 1'b1);   // learn A at idx 0
      frame_rows(ADDR_A, ADDR_B, 2'd1, 1'b1);   // B at idx 1
      check_row(`AL_D_PORT, 32'h04, "lookup hit port 2");
      frame_rows(ADDR_C, ADDR_B, 2'd1, 1'b1);
      check_row(`AL_D_PORT, 32'h0D, "lookup miss floods");
      frame_rows(MAC_M, ADDR_B, 2'd1, 1'b1);
      check_row(`AL_D_PORT, 32'h10, "own address");

      // table full, A holds the oldest stamp
      for (int i = 1; i <= 6; i++)
         frame_rows(ADDR_C, src_addr(i), 2'(i), 1'b1);   // idx 2..7
      frame_rows(ADDR_C, src_addr(7), 2'd3, 1'b0);
      check_row(`AL_STATUS, 32'h4, "status reused");
      check_row(`AL_LST_INV_ADDR_L, ADDR_A[31:0], "reuse addr_l");
      check_row(`AL_LST_INV_ADDR_U, {16'd0, ADDR_A[47:32]}, "reuse addr_u");
      check_row(`AL_LST_INV_PORT, 32'd2, "reuse port");
      check_row(`AL_STATUS, 32'h0, "reused cleared");

      // aging, only src 6 is refreshed after the wait
      add_row(OP_CYC, '0, 32'd300, '0, "");
      frame_rows(ADDR_C, src_addr(6), 2'd2, 1'b1);
      write_row(`AL_BB_AGE, 32'd100);
      write_row(`AL_COMMAND, 32'd1);
      add_row(OP_IDLE, '0, '0, '0, "");
      check_row(`AL_LST_INV_ADDR_L, 32'(src_addr(5)), "aged addr_l");
      check_row(`AL_LST_INV_ADDR_U, 32'h0051, "aged addr_u");
      check_row(`AL_LST_INV_PORT, 32'd1, "aged port");
      frame_rows(src_addr(5), src_addr(6), 2'd2, 1'b1);
      check_row(`AL_D_PORT, 32'h0B, "aged entry floods");
      write_row(`AL_BB_AGE, 32'hFFFF_FFFF);
      write_row(`AL_COMMAND, 32'd1);
      add_row(OP_IDLE, '0, '0, '0, "");
      check_row(`AL_LST_INV_ADDR_L, 32'h5, "no new invalidation");
      frame_rows(src_addr(6), ADDR_B, 2'd1, 1'b1);   // B back into idx 0
      check_row(`AL_D_PORT, 32'h04, "survivor still hits");

      // sweep written mid check, bb_age 0 would clear the table
      write_row(`AL_BB_AGE, 32'd0);
      frame_rows(src_addr(6), ADDR_B, 2'd1, 1'b0);
      op_q.pop_back();   // replace the fixed wait
      addr_q.pop_back();
      data_q.pop_back();
      exp_q.pop_back();
      name_q.pop_back();
      write_row(`AL_COMMAND, 32'd1);   // lands while active
      add_row(OP_IDLE, '0, '0, '0, "");
      check_row(`AL_STATUS, 32'h0, "idle after one check");
      check_row(`AL_D_PORT, 32'h04, "busy check result");
      frame_rows(ADDR_B, src_addr(6), 2'd2, 1'b1);
      check_row(`AL_D_PORT, 32'h02, "entries survive");

      // time base, reads 43 cycles apart at one tick per 4
      write_row(`AL_DIV_CLK, 32'd3);
      add_row(OP_TMARK, `AL_CUR_TIME, '0, '0, "");
      add_row(OP_CYC, '0, 32'd40, '0, "");
      add_row(OP_TDIFF, `AL_CUR_TIME, 32'd9, 32'd11, "cur_time rate");
   endtask

   // ------------------------------------------------------------------------
   // apb transfers, one idle cycle after each
   task automatic apb_write(input logic [6:0] a, input logic [31:0] d);
      @(negedge pclk9);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = a;
      pwdata  = d;
      @(negedge pclk9);
      penable = 1'b1;
      @(negedge pclk9);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [6:0] a, output logic [31:0] d);
      @(negedge pclk9);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = a;
      @(negedge pclk9);
      penable = 1'b1;
      d       = prdata;   // registered at end of setup
      @(negedge pclk9);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_idle();
      logic [31:0] st;
      do
         apb_read(`AL_STATUS, st);
      while (st[0]);
   endtask

   task automatic check_equal(input string n, input logic [31:0] e, input logic [31:0] a);
      check_cnt++;
      assert (a === e) else
      begin
         $display("FAIL %s: expected %08h, actual %08h", n, e, a);
         fail_cnt++;
      end
      if (a === e)
         $display("pass %s", n);
   endtask

   task automatic check_range(input string n, input logic [31:0] lo, input logic [31:0] hi,
                              input logic [31:0] a);
      check_cnt++;
      assert ((a >= lo) && (a <= hi)) else
      begin
         $display("FAIL %s: expected %0d..%0d, actual %0d", n, lo, hi, a);
         fail_cnt++;
      end
      if ((a >= lo) && (a <= hi))
         $display("pass %s", n);
   endtask

   task automatic run_row(input int r);
      logic [31:0] rd;
      case (op_q[r])
         OP_WR    : apb_write(addr_q[r], data_q[r]);
         OP_RD    :
         begin
            apb_read(addr_q[r], rd);
            check_equal(name_q[r], exp_q[r], rd);
         end
         OP_IDLE  : wait_idle();
         OP_CYC   : repeat (data_q[r]) @(negedge pclk9);
         OP_TMARK : apb_read(addr_q[r], time_mark);
         default  :
         begin
            apb_read(addr_q[r], rd);
            check_range(name_q[r], data_q[r], exp_q[r], rd - time_mark);
         end
      endcase
   endtask

   // ------------------------------------------------------------------------
   initial
   begin
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      n_p_reset9 = 1'b0;
      build_table();
      cycle_limit = 64 * op_q.size() + 2000;
      repeat (4) @(negedge pclk9);
      n_p_reset9 = 1'b1;
      for (row = 0; row < op_q.size(); row++)
         run_row(row);
      $display("%0d checks, %0d failed", check_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule
